// File: src/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// wishbone address width, one byte per register
`define UART_ADR_W 3

// register map
`define UART_REG_DATA    3'd0
`define UART_REG_STATUS  3'd1
`define UART_REG_CTRL    3'd2
`define UART_REG_BAUD_LO 3'd3
`define UART_REG_BAUD_HI 3'd4
`define UART_REG_FRAC    3'd5

// divisors after reset
`define UART_BAUD_RESET 16'd433
`define UART_FRAC_RESET 8'd0

`endif

// File: src/uart_pkg.sv
package uart_pkg;

    // one data byte, also the bus data width
    typedef logic [7:0] uart_byte_t;

    // bit period is divisor+1 clocks, plus one on accumulator carry
    typedef logic [15:0] uart_baud_t;
    typedef logic [7:0] uart_frac_t;

    // mode[1:0], hunt value, discard, rx en, hunt en, tx en, tx ninth bit
    typedef logic [7:0] uart_ctrl_t;

    // rx valid, tx free, noise, framing, parity, overrun, ninth bit, zero
    typedef logic [7:0] uart_status_t;

    // data byte with its ninth bit on top
    typedef logic [8:0] uart_frame_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_e;

endpackage

// File: src/uart_regs.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`UART_ADR_W-1:0] wb_adr,
    input  uart_pkg::uart_byte_t   wb_wdata,
    output uart_pkg::uart_byte_t   wb_rdata,
    output logic                   wb_ack,
    input  logic                   rx_valid,
    input  uart_pkg::uart_byte_t   rx_data,
    input  logic [4:0]             rx_status,
    input  logic                   tx_free,
    output uart_pkg::uart_ctrl_t   ctrl,
    output uart_pkg::uart_baud_t   baud,
    output uart_pkg::uart_frac_t   frac,
    output logic                   tx_write,
    output uart_pkg::uart_byte_t   tx_data,
    output logic                   rx_read
);

    logic                   req;
    logic                   wr_req;
    logic                   rd_req;
    uart_pkg::uart_status_t status;

    // a new request, not the tail of one already acknowledged
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = req && wb_we;
    assign rd_req = req && !wb_we;

    // error and ninth-bit fields come straight from the receiver
    assign status = {1'b0, rx_status, tx_free, rx_valid};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            tx_write <= 1'b0;
            rx_read  <= 1'b0;
            // transmitter enabled out of reset
            ctrl     <= 8'h40;
            baud     <= `UART_BAUD_RESET;
            frac     <= `UART_FRAC_RESET;
        end else begin
            wb_ack <= req;
            // a full holding register drops the byte, the bus still gets ack
            tx_write <= wr_req && (wb_adr == `UART_REG_DATA) && tx_free;
            rx_read  <= rd_req && (wb_adr == `UART_REG_DATA);
            if (wr_req) begin
                case (wb_adr)
                    `UART_REG_CTRL:    ctrl <= wb_wdata;
                    `UART_REG_BAUD_LO: baud[7:0] <= wb_wdata;
                    `UART_REG_BAUD_HI: baud[15:8] <= wb_wdata;
                    `UART_REG_FRAC:    frac <= wb_wdata;
                    default: ;
                endcase
            end
        end
    end

    // read data is captured on the request, valid with ack
    always_ff @(posedge clk) begin
        if (wr_req && (wb_adr == `UART_REG_DATA)) begin
            tx_data <= wb_wdata;
        end
        if (rd_req) begin
            case (wb_adr)
                `UART_REG_DATA:    wb_rdata <= rx_data;
                `UART_REG_STATUS:  wb_rdata <= status;
                `UART_REG_CTRL:    wb_rdata <= ctrl;
                `UART_REG_BAUD_LO: wb_rdata <= baud[7:0];
                `UART_REG_BAUD_HI: wb_rdata <= baud[15:8];
                `UART_REG_FRAC:    wb_rdata <= frac;
                default:           wb_rdata <= '0;
            endcase
        end
    end

    // classic cycle: one ack per request, master drops stb on seeing it
    a_ack_single : assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack
    );

endmodule

// File: src/uart_frac_baud.sv
`timescale 1ns/100ps

module uart_frac_baud (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_baud_t baud,
    input  uart_pkg::uart_frac_t frac,
    output logic                 baud_tick
);

    // one spare bit so baud+1 still fits
    logic [16:0] cnt;
    logic [16:0] limit;
    logic [8:0]  acc;

    // carry from the previous bit stretches this one by a clock
    assign limit = {1'b0, baud} + 17'(acc[8]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            acc       <= '0;
            baud_tick <= 1'b0;
        end else if (cnt >= limit) begin
            cnt       <= '0;
            acc       <= {1'b0, acc[7:0]} + {1'b0, frac};
            baud_tick <= 1'b1;
        end else begin
            cnt       <= cnt + 17'd1;
            baud_tick <= 1'b0;
        end
    end

endmodule

// File: src/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rxd,
    input  uart_pkg::uart_ctrl_t ctrl,
    input  uart_pkg::uart_baud_t baud,
    input  uart_pkg::uart_frac_t frac,
    input  logic                 rx_read,
    output logic                 rx_valid,
    output uart_pkg::uart_byte_t rx_data,
    output logic [4:0]           rx_status
);

    uart_pkg::rx_state_e   state;
    uart_pkg::uart_frame_t shift;
    uart_pkg::uart_frame_t stage_frame;
    logic        rxd_meta;
    logic        rxd_sync;
    logic        rxd_prev;
    logic        armed;
    logic [16:0] bit_cnt;
    logic [16:0] limit;
    logic [15:0] half;
    logic [8:0]  acc;
    logic [3:0]  bit_idx;
    logic [3:0]  last_idx;
    logic        noise_acc;
    logic        pair_noise;
    logic        start_det;
    logic        mid;
    logic        bit_end;
    logic        done;
    logic        stage_valid;
    logic        stage_ovr;
    logic        stage_frm;
    logic        stage_noise;
    logic        move;
    logic        par_err;
    logic        accept;

    // two samples one clock apart around the sample point
    assign pair_noise = rxd_prev != rxd_sync;
    assign start_det  = (state == uart_pkg::RX_IDLE) && ctrl[4] && armed
                        && !rxd_prev && !rxd_sync;

    // timer restarts on every start edge
    assign limit    = {1'b0, baud} + 17'(acc[8]);
    assign half     = {1'b0, baud[15:1]} + 16'd1;
    assign mid      = (state != uart_pkg::RX_IDLE) && (bit_cnt == {1'b0, half});
    assign bit_end  = bit_cnt >= limit;
    assign last_idx = (ctrl[1:0] == 2'b00) ? 4'd7 : 4'd8;
    assign done     = mid && (state == uart_pkg::RX_STOP);

    // odd parity in mode 01, even in mode 10
    assign par_err = ((ctrl[1:0] == 2'b01) && !(^stage_frame))
                     || ((ctrl[1:0] == 2'b10) && (^stage_frame));
    assign accept  = (!ctrl[3] || !(par_err || stage_frm || stage_noise))
                     && (!ctrl[5] || (ctrl[1:0] != 2'b11) || (stage_frame[8] == ctrl[2]));
    assign move    = stage_valid && !rx_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= uart_pkg::RX_IDLE;
            armed     <= 1'b0;
            bit_cnt   <= '0;
            acc       <= '0;
            bit_idx   <= '0;
            noise_acc <= 1'b0;
        end else begin
            if (state == uart_pkg::RX_IDLE || start_det || bit_end) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 17'd1;
            end
            if (state == uart_pkg::RX_IDLE) begin
                acc <= '0;
            end else if (bit_end) begin
                acc <= {1'b0, acc[7:0]} + {1'b0, frac};
            end
            // a start needs the line seen high first, so a low stop does not retrigger
            if (state == uart_pkg::RX_IDLE && rxd_prev && rxd_sync) begin
                armed <= 1'b1;
            end else if (start_det) begin
                armed <= 1'b0;
            end
            if (mid) begin
                noise_acc <= noise_acc | pair_noise;
            end
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (start_det) begin
                        state     <= uart_pkg::RX_START;
                        noise_acc <= 1'b0;
                    end
                end
                uart_pkg::RX_START: begin
                    // high at mid start bit is a glitch
                    if (mid && rxd_sync) begin
                        state <= uart_pkg::RX_IDLE;
                    end else if (bit_end) begin
                        state   <= uart_pkg::RX_DATA;
                        bit_idx <= '0;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == last_idx) begin
                            state <= uart_pkg::RX_STOP;
                        end
                        bit_idx <= bit_idx + 4'd1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (mid) begin
                        state <= uart_pkg::RX_IDLE;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_det) begin
            shift <= '0;
        end else if (mid && (state == uart_pkg::RX_DATA)) begin
            shift[bit_idx] <= rxd_sync;
        end
        if (done) begin
            stage_frame <= shift;
        end
        if (move) begin
            rx_data <= stage_frame[7:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            stage_ovr   <= 1'b0;
            stage_frm   <= 1'b0;
            stage_noise <= 1'b0;
            rx_valid    <= 1'b0;
            rx_status   <= '0;
        end else begin
            if (rx_read) begin
                rx_valid <= 1'b0;
            end
            if (move) begin
                stage_valid <= 1'b0;
                rx_valid    <= accept;
                rx_status   <= {stage_frame[8], stage_ovr, par_err, stage_frm, stage_noise};
            end
            // a full stage that is not moving now gets overwritten
            if (done) begin
                stage_valid <= 1'b1;
                stage_ovr   <= stage_valid && !move;
                stage_frm   <= !rxd_sync;
                stage_noise <= noise_acc | pair_noise;
            end
        end
    end

    a_valid_after_move : assert property (
        @(posedge clk) disable iff (!rst_n) $rose(rx_valid) |-> $past(move)
    );

endmodule

// File: src/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_ctrl_t ctrl,
    input  logic                 baud_tick,
    input  logic                 tx_write,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx_free,
    output logic                 txd
);

    uart_pkg::tx_state_e  state;
    uart_pkg::uart_byte_t hold_data;
    logic        hold_valid;
    logic        loaded;
    logic [10:0] shreg;
    logic [3:0]  bit_idx;
    logic [3:0]  last_idx;
    logic        ninth;
    logic        load;
    logic        start;
    logic        step;
    logic        finish;

    // eight-bit mode sends a one here, which acts as the stop bit
    always_comb begin
        case (ctrl[1:0])
            2'b01:   ninth = ~^hold_data;
            2'b10:   ninth = ^hold_data;
            2'b11:   ninth = ctrl[7];
            default: ninth = 1'b1;
        endcase
    end

    assign tx_free = ctrl[6] && !hold_valid;
    assign load    = hold_valid && !loaded;
    assign start   = (state == uart_pkg::TX_IDLE) && loaded && baud_tick;
    assign step    = (state == uart_pkg::TX_SHIFT) && baud_tick && (bit_idx != last_idx);
    assign finish  = (state == uart_pkg::TX_SHIFT) && baud_tick && (bit_idx == last_idx);

    always_ff @(posedge clk) begin
        if (tx_write && !hold_valid) begin
            hold_data <= tx_data;
        end
        // stop, ninth, data, start, LSB first
        if (load) begin
            shreg <= {1'b1, ninth, hold_data, 1'b0};
        end else if (start || step) begin
            shreg <= {1'b1, shreg[10:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= uart_pkg::TX_IDLE;
            hold_valid <= 1'b0;
            loaded     <= 1'b0;
            bit_idx    <= '0;
            last_idx   <= '0;
            txd        <= 1'b1;
        end else begin
            if (tx_write && !hold_valid) begin
                hold_valid <= 1'b1;
            end else if (load) begin
                hold_valid <= 1'b0;
            end
            if (load) begin
                loaded   <= 1'b1;
                last_idx <= (ctrl[1:0] == 2'b00) ? 4'd9 : 4'd10;
            end
            if (start) begin
                state   <= uart_pkg::TX_SHIFT;
                bit_idx <= '0;
                txd     <= shreg[0];
            end else if (step) begin
                bit_idx <= bit_idx + 4'd1;
                txd     <= shreg[0];
            end else if (finish) begin
                state  <= uart_pkg::TX_IDLE;
                loaded <= 1'b0;
                txd    <= 1'b1;
            end
        end
    end

    a_idle_high : assert property (
        @(posedge clk) disable iff (!rst_n) (state == uart_pkg::TX_IDLE) |-> txd
    );

endmodule

// File: src/uart_top.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module uart_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`UART_ADR_W-1:0] wb_adr,
    input  uart_pkg::uart_byte_t   wb_wdata,
    output uart_pkg::uart_byte_t   wb_rdata,
    output logic                   wb_ack,
    input  logic                   rxd,
    output logic                   txd
);

    uart_pkg::uart_ctrl_t ctrl;
    uart_pkg::uart_baud_t baud;
    uart_pkg::uart_frac_t frac;
    uart_pkg::uart_byte_t tx_data;
    uart_pkg::uart_byte_t rx_data;
    logic [4:0] rx_status;
    logic       rx_valid;
    logic       rx_read;
    logic       tx_write;
    logic       tx_free;
    logic       baud_tick;

    uart_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_status (rx_status),
        .tx_free   (tx_free),
        .ctrl      (ctrl),
        .baud      (baud),
        .frac      (frac),
        .tx_write  (tx_write),
        .tx_data   (tx_data),
        .rx_read   (rx_read)
    );

    // shared divisors, the receiver runs its own timer
    uart_frac_baud u_baud (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud      (baud),
        .frac      (frac),
        .baud_tick (baud_tick)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .ctrl      (ctrl),
        .baud      (baud),
        .frac      (frac),
        .rx_read   (rx_read),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_status (rx_status)
    );

    uart_tx u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .baud_tick (baud_tick),
        .tx_write  (tx_write),
        .tx_data   (tx_data),
        .tx_free   (tx_free),
        .txd       (txd)
    );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held low for 4 cycles
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: dv/tb_uart.sv
`timescale 1ns/100ps
`include "uart_defines.svh"

module tb_uart;

    // bit period is BAUD_TEST+1 clocks, frac stays 0
    localparam int BAUD_TEST      = 15;
    localparam int BIT_CLKS       = BAUD_TEST + 1;
    localparam int MAX_FRAMES     = 14;
    localparam int TIMEOUT_CYCLES = MAX_FRAMES * 11 * BIT_CLKS * 2 + 2000;
    localparam logic [15:0] BAUD_RESET = `UART_BAUD_RESET;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`UART_ADR_W-1:0] wb_adr;
    uart_pkg::uart_byte_t   wb_wdata;
    uart_pkg::uart_byte_t   wb_rdata;
    logic                   wb_ack;
    logic                   rxd;
    logic                   txd;
    uart_pkg::uart_ctrl_t   cur_ctrl;
    int unsigned            lcg_state = 13213;
    int                     cycles = 0;
    int                     errors = 0;
    int                     checks = 0;
    int                     last_errors = 0;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uart_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .rxd      (rxd),
        .txd      (txd)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic uart_pkg::uart_byte_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // status layout: zero, ninth, overrun, parity, framing, noise, tx free, rx valid
    function automatic uart_pkg::uart_status_t expected_status(input logic valid,
                                                               input logic frm,
                                                               input logic par,
                                                               input logic ovr,
                                                               input logic ninth);
        return {1'b0, ninth, ovr, par, frm, 1'b0, cur_ctrl[6], valid};
    endfunction

    task automatic check_byte(input string name, input uart_pkg::uart_byte_t got,
                              input uart_pkg::uart_byte_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input uart_pkg::uart_status_t got,
                                input uart_pkg::uart_status_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_frame(input string name, input uart_pkg::uart_frame_t got,
                               input uart_pkg::uart_frame_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d errors", name, errors - last_errors);
        last_errors = errors;
    endtask

    task automatic wb_write(input logic [`UART_ADR_W-1:0] adr, input uart_pkg::uart_byte_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_wdata <= data;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [`UART_ADR_W-1:0] adr, output uart_pkg::uart_byte_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        data = wb_rdata;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic set_ctrl(input uart_pkg::uart_ctrl_t value);
        cur_ctrl = value;
        wb_write(`UART_REG_CTRL, value);
    endtask

    // poll status until a character is readable
    task automatic wait_rx(output uart_pkg::uart_status_t st);
        wb_read(`UART_REG_STATUS, st);
        while (!st[0]) wb_read(`UART_REG_STATUS, st);
    endtask

    // start, data LSB first, optional ninth, stop, then one idle bit
    task automatic send_serial(input uart_pkg::uart_byte_t data, input logic ninth,
                               input logic nine_bits, input logic stop_bit);
        int i;
        @(posedge clk);
        rxd <= 1'b0;
        repeat (BIT_CLKS) @(posedge clk);
        for (i = 0; i < 8; i++) begin
            rxd <= data[i];
            repeat (BIT_CLKS) @(posedge clk);
        end
        if (nine_bits) begin
            rxd <= ninth;
            repeat (BIT_CLKS) @(posedge clk);
        end
        rxd <= stop_bit;
        repeat (BIT_CLKS) @(posedge clk);
        rxd <= 1'b1;
        repeat (BIT_CLKS) @(posedge clk);
    endtask

    // in eight-bit mode the stop bit lands in frame[8]
    task automatic recv_serial(input logic nine_bits, output uart_pkg::uart_frame_t frame);
        int i;
        @(negedge clk);
        while (txd) @(negedge clk);
        repeat (BIT_CLKS / 2) @(negedge clk);
        if (txd !== 1'b0) begin
            errors = errors + 1;
            $display("txd start bit is high at its middle");
        end
        for (i = 0; i < 9; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            frame[i] = txd;
        end
        if (nine_bits) begin
            repeat (BIT_CLKS) @(negedge clk);
            if (txd !== 1'b1) begin
                errors = errors + 1;
                $display("txd stop bit is low at its middle");
            end
        end
    endtask

    task automatic write_readback(input logic [`UART_ADR_W-1:0] adr, input string name);
        uart_pkg::uart_byte_t value;
        uart_pkg::uart_byte_t got;
        value = lcg_next();
        wb_write(adr, value);
        wb_read(adr, got);
        check_byte(name, got, value);
    endtask

    task automatic test_registers();
        uart_pkg::uart_byte_t   got;
        uart_pkg::uart_status_t st;
        // transmitter enabled out of reset, receiver empty
        wb_read(`UART_REG_STATUS, st);
        check_status("status after reset", st, 8'h02);
        wb_read(`UART_REG_BAUD_LO, got);
        check_byte("baud_lo after reset", got, BAUD_RESET[7:0]);
        wb_read(`UART_REG_BAUD_HI, got);
        check_byte("baud_hi after reset", got, BAUD_RESET[15:8]);
        write_readback(`UART_REG_CTRL, "ctrl");
        write_readback(`UART_REG_BAUD_LO, "baud_lo");
        write_readback(`UART_REG_BAUD_HI, "baud_hi");
        write_readback(`UART_REG_FRAC, "frac");
        wb_write(`UART_REG_BAUD_LO, 8'(BAUD_TEST));
        wb_write(`UART_REG_BAUD_HI, 8'h00);
        wb_write(`UART_REG_FRAC, 8'h00);
        set_ctrl(8'h40);
        wb_read(`UART_REG_STATUS, st);
        check_status("status tx enabled", st, 8'h02);
        report_test("registers");
    endtask

    task automatic test_transmit();
        uart_pkg::uart_byte_t  data;
        uart_pkg::uart_frame_t frame;
        set_ctrl(8'h40);
        data = lcg_next();
        wb_write(`UART_REG_DATA, data);
        recv_serial(1'b0, frame);
        check_frame("txd frame eight-bit", frame, {1'b1, data});
        // even parity, ninth bit is the xor of the data
        set_ctrl(8'h42);
        data = lcg_next();
        wb_write(`UART_REG_DATA, data);
        recv_serial(1'b1, frame);
        check_frame("txd frame even", frame, {^data, data});
        report_test("transmit");
    endtask

    task automatic test_receive();
        uart_pkg::uart_byte_t   data;
        uart_pkg::uart_byte_t   got;
        uart_pkg::uart_status_t st;
        logic                   par;
        set_ctrl(8'h51);
        data = lcg_next();
        par = ~^data;
        send_serial(data, par, 1'b1, 1'b1);
        wait_rx(st);
        check_status("status odd clean", st, expected_status(1'b1, 1'b0, 1'b0, 1'b0, par));
        wb_read(`UART_REG_DATA, got);
        check_byte("rx_data odd clean", got, data);
        // parity bit inverted
        data = lcg_next();
        par = ^data;
        send_serial(data, par, 1'b1, 1'b1);
        wait_rx(st);
        check_status("status parity error", st, expected_status(1'b1, 1'b0, 1'b1, 1'b0, par));
        wb_read(`UART_REG_DATA, got);
        check_byte("rx_data parity error", got, data);
        // stop bit held low
        data = lcg_next();
        par = ~^data;
        send_serial(data, par, 1'b1, 1'b0);
        wait_rx(st);
        check_status("status framing error", st, expected_status(1'b1, 1'b1, 1'b0, 1'b0, par));
        wb_read(`UART_REG_DATA, got);
        check_byte("rx_data framing error", got, data);
        report_test("receive");
    endtask

    task automatic test_discard();
        uart_pkg::uart_byte_t   data;
        uart_pkg::uart_byte_t   got;
        uart_pkg::uart_status_t st;
        logic                   par;
        set_ctrl(8'h59);
        data = lcg_next();
        par = ^data;
        send_serial(data, par, 1'b1, 1'b1);
        // frame fully stored by the end of its idle bit
        wb_read(`UART_REG_STATUS, st);
        check_status("status discarded", st, expected_status(1'b0, 1'b0, 1'b1, 1'b0, par));
        data = lcg_next();
        par = ~^data;
        send_serial(data, par, 1'b1, 1'b1);
        wait_rx(st);
        check_status("status after discard", st, expected_status(1'b1, 1'b0, 1'b0, 1'b0, par));
        wb_read(`UART_REG_DATA, got);
        check_byte("rx_data after discard", got, data);
        report_test("discard");
    endtask

    task automatic test_hunt();
        uart_pkg::uart_byte_t   data;
        uart_pkg::uart_byte_t   got;
        uart_pkg::uart_status_t st;
        // ninth-bit mode, hunt for a one
        set_ctrl(8'h77);
        data = lcg_next();
        send_serial(data, 1'b0, 1'b1, 1'b1);
        wb_read(`UART_REG_STATUS, st);
        check_status("status data frame", st, expected_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        data = lcg_next();
        send_serial(data, 1'b1, 1'b1, 1'b1);
        wait_rx(st);
        check_status("status address frame", st, expected_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
        wb_read(`UART_REG_DATA, got);
        check_byte("rx_data address frame", got, data);
        report_test("hunt");
    endtask

    task automatic test_overrun();
        uart_pkg::uart_byte_t   first;
        uart_pkg::uart_byte_t   second;
        uart_pkg::uart_byte_t   third;
        uart_pkg::uart_byte_t   got;
        uart_pkg::uart_status_t st;
        set_ctrl(8'h50);
        first = lcg_next();
        second = lcg_next();
        third = lcg_next();
        send_serial(first, 1'b0, 1'b0, 1'b1);
        send_serial(second, 1'b0, 1'b0, 1'b1);
        send_serial(third, 1'b0, 1'b0, 1'b1);
        wait_rx(st);
        check_status("status first byte", st, expected_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        wb_read(`UART_REG_DATA, got);
        check_byte("rx_data first byte", got, first);
        // second frame was overwritten in the staging register
        wait_rx(st);
        check_status("status overrun", st, expected_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
        wb_read(`UART_REG_DATA, got);
        check_byte("rx_data after overrun", got, third);
        report_test("overrun");
    endtask

    initial begin
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_wdata <= '0;
        rxd      <= 1'b1;
        cur_ctrl = 8'h40;
        @(posedge rst_n);
        test_registers();
        test_transmit();
        test_receive();
        test_discard();
        test_hunt();
        test_overrun();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+src
src/uart_pkg.sv
src/uart_regs.sv
src/uart_frac_baud.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_top.sv
dv/tb_clk_gen.sv
dv/tb_uart.sv

// File: Makefile
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_uart with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_uart -Mdir $(BUILD) -o tb_uart
	./$(BUILD)/tb_uart | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
